// File: mem_pkg.sv
package mem_pkg;

    // **************************************************
    // Memory bus geometry
    // **************************************************

    // Word address, 256 words
    localparam int addr_width = 8;

    localparam int data_width = 32; // One bus word

    // Cycles from accept edge to response pulse
    localparam int mem_delay = 4;

    // **************************************************
    // Request operation
    // **************************************************

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_e;

endpackage

// File: soc_pkg.sv
package soc_pkg;

    // Owner of the in-flight memory request
    typedef enum logic [1:0] {
        arb_idle = 2'd0,
        arb_inst = 2'd1,
        arb_data = 2'd2
    } arb_state_e;

    // Timebase
    localparam int fmax_mhz   = 27; // Clock cycles per microsecond
    localparam int time_width = 64;

endpackage

// File: mem_req_port.sv
`timescale 1ns/1ps

module mem_req_port (
    input  logic                            clk_in,
    input  logic                            rst_n,
    input  logic                            req_valid,
    input  mem_pkg::mem_op_e                req_op,
    input  logic [mem_pkg::addr_width-1:0]  req_addr,
    input  logic [mem_pkg::data_width-1:0]  req_wdata,
    input  logic                            grant,
    input  logic                            done,
    input  logic [mem_pkg::data_width-1:0]  done_rdata,
    output logic                            req_ready,
    output logic                            rsp_valid,
    output logic [mem_pkg::data_width-1:0]  rsp_rdata,
    output logic                            pend,
    output mem_pkg::mem_op_e                pend_op,
    output logic [mem_pkg::addr_width-1:0]  pend_addr,
    output logic [mem_pkg::data_width-1:0]  pend_wdata
);
    import mem_pkg::*;

    logic busy; // Request accepted, response not yet returned
    logic accept;

    assign accept = req_valid && req_ready;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            pend <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
            pend <= 1'b1;
        end else begin
            if (grant) pend <= 1'b0; // Issued to memory
            if (done)  busy <= 1'b0;
        end
    end

    // Request payload, held until the grant
    always_ff @(posedge clk_in) begin
        if (accept) begin
            pend_op    <= req_op;
            pend_addr  <= req_addr;
            pend_wdata <= req_wdata;
        end
    end

    assign req_ready = !busy;
    assign rsp_valid = busy && done; // Same cycle as done
    assign rsp_rdata = done_rdata;

endmodule

// File: mem_bus_arbiter.sv
`timescale 1ns/1ps

module mem_bus_arbiter (
    input  logic                            clk_in,
    input  logic                            rst_n,
    input  logic                            inst_pend,
    input  logic [mem_pkg::addr_width-1:0]  inst_addr,
    input  logic                            data_pend,
    input  mem_pkg::mem_op_e                data_op,
    input  logic [mem_pkg::addr_width-1:0]  data_addr,
    input  logic [mem_pkg::data_width-1:0]  data_wdata,
    input  logic                            mem_ready,
    input  logic                            mem_rsp_valid,
    input  logic [mem_pkg::data_width-1:0]  mem_rsp_rdata,
    output logic                            inst_grant,
    output logic                            data_grant,
    output logic                            inst_done,
    output logic                            data_done,
    output logic [mem_pkg::data_width-1:0]  done_rdata,
    output logic                            mem_valid,
    output mem_pkg::mem_op_e                mem_op,
    output logic [mem_pkg::addr_width-1:0]  mem_addr,
    output logic [mem_pkg::data_width-1:0]  mem_wdata
);
    import mem_pkg::*;
    import soc_pkg::*;

    arb_state_e state;
    logic       last_data; // Data port was granted last
    logic       pick_inst;
    logic       pick_data;

    // **************************************************
    // Selection
    // **************************************************

    // Ties go to the port that lost last time
    assign pick_inst = inst_pend && (!data_pend || last_data);
    assign pick_data = data_pend && !pick_inst;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state      <= arb_idle;
            last_data  <= 1'b1; // Instruction wins the first tie
            mem_valid  <= 1'b0;
            inst_grant <= 1'b0;
            data_grant <= 1'b0;
        end else begin
            inst_grant <= 1'b0;
            data_grant <= 1'b0;
            if (mem_valid && mem_ready) mem_valid <= 1'b0;
            case (state)
                arb_idle: begin
                    if (pick_inst) begin
                        state      <= arb_inst;
                        mem_valid  <= 1'b1;
                        inst_grant <= 1'b1;
                        last_data  <= 1'b0;
                    end else if (pick_data) begin
                        state      <= arb_data;
                        mem_valid  <= 1'b1;
                        data_grant <= 1'b1;
                        last_data  <= 1'b1;
                    end
                end
                arb_inst, arb_data: begin
                    if (mem_rsp_valid) state <= arb_idle;
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // Memory request payload
    always_ff @(posedge clk_in) begin
        if (state == arb_idle) begin
            if (pick_inst) begin
                mem_op    <= op_read; // Fetch is read only
                mem_addr  <= inst_addr;
                mem_wdata <= '0;
            end else if (pick_data) begin
                mem_op    <= data_op;
                mem_addr  <= data_addr;
                mem_wdata <= data_wdata;
            end
        end
    end

    // **************************************************
    // Response steering
    // **************************************************

    assign inst_done  = mem_rsp_valid && (state == arb_inst);
    assign data_done  = mem_rsp_valid && (state == arb_data);
    assign done_rdata = mem_rsp_rdata;

endmodule

// File: mem_delay_ram.sv
`timescale 1ns/1ps

module mem_delay_ram (
    input  logic                            clk_in,
    input  logic                            rst_n,
    input  logic                            mem_valid,
    input  mem_pkg::mem_op_e                mem_op,
    input  logic [mem_pkg::addr_width-1:0]  mem_addr,
    input  logic [mem_pkg::data_width-1:0]  mem_wdata,
    output logic                            mem_ready,
    output logic                            mem_rsp_valid,
    output logic [mem_pkg::data_width-1:0]  mem_rsp_rdata
);
    import mem_pkg::*;

    localparam int depth     = 2 ** addr_width;
    localparam int cnt_width = $clog2(mem_delay + 1);

    logic [data_width-1:0] mem_array [depth];
    logic [cnt_width-1:0]  delay_cnt; // Zero when idle
    logic                  accept;

    assign accept = mem_valid && mem_ready;

    // **************************************************
    // Latency counter
    // **************************************************

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            delay_cnt <= '0;
        end else if (accept) begin
            delay_cnt <= cnt_width'(mem_delay);
        end else if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
        end
    end

    assign mem_ready     = (delay_cnt == '0);
    assign mem_rsp_valid = (delay_cnt == cnt_width'(1)); // Last busy cycle

    // **************************************************
    // Storage
    // **************************************************

    // Read samples the array before a same-edge write lands
    always_ff @(posedge clk_in) begin
        if (accept) begin
            mem_rsp_rdata <= mem_array[mem_addr];
            if (mem_op == op_write) begin
                mem_array[mem_addr] <= mem_wdata;
            end
        end
    end

endmodule

// File: time_counter.sv
`timescale 1ns/1ps

module time_counter (
    input  logic                            clk_in,
    input  logic                            rst_n,
    input  logic [soc_pkg::time_width-1:0]  mtimecmp,
    output logic [soc_pkg::time_width-1:0]  cycle_count,
    output logic [soc_pkg::time_width-1:0]  time_us,
    output logic                            timer_irq
);
    import soc_pkg::*;

    localparam int presc_width = $clog2(fmax_mhz);

    logic [presc_width-1:0] prescale; // Cycles within the current microsecond

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            cycle_count <= '0;
            time_us     <= '0;
            prescale    <= '0;
            timer_irq   <= 1'b0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
            if (prescale == presc_width'(fmax_mhz - 1)) begin
                prescale <= '0;
                time_us  <= time_us + 1'b1;
            end else begin
                prescale <= prescale + 1'b1;
            end
            timer_irq <= (time_us >= mtimecmp); // One cycle behind the compare
        end
    end

endmodule

// File: mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys (
    input  logic                            clk_in,
    input  logic                            rst_n,
    input  logic                            inst_req_valid,
    output logic                            inst_req_ready,
    input  logic [mem_pkg::addr_width-1:0]  inst_req_addr,
    output logic                            inst_rsp_valid,
    output logic [mem_pkg::data_width-1:0]  inst_rsp_rdata,
    input  logic                            data_req_valid,
    output logic                            data_req_ready,
    input  mem_pkg::mem_op_e                data_req_op,
    input  logic [mem_pkg::addr_width-1:0]  data_req_addr,
    input  logic [mem_pkg::data_width-1:0]  data_req_wdata,
    output logic                            data_rsp_valid,
    output logic [mem_pkg::data_width-1:0]  data_rsp_rdata,
    input  logic [soc_pkg::time_width-1:0]  mtimecmp,
    output logic [soc_pkg::time_width-1:0]  cycle_count,
    output logic [soc_pkg::time_width-1:0]  time_us,
    output logic                            timer_irq
);
    import mem_pkg::*;

    logic                  inst_pend, inst_grant, inst_done;
    logic [addr_width-1:0] inst_addr;
    logic                  data_pend, data_grant, data_done;
    mem_op_e               data_op;
    logic [addr_width-1:0] data_addr;
    logic [data_width-1:0] data_wdata;
    logic [data_width-1:0] done_rdata;

    logic                  mem_valid, mem_ready, mem_rsp_valid;
    mem_op_e               mem_op;
    logic [addr_width-1:0] mem_addr;
    logic [data_width-1:0] mem_wdata, mem_rsp_rdata;

    // **************************************************
    // Request ports
    // **************************************************

    // Fetch side never writes
    mem_req_port inst_port (
        .clk_in(clk_in), .rst_n(rst_n),
        .req_valid(inst_req_valid), .req_op(op_read),
        .req_addr(inst_req_addr), .req_wdata('0),
        .grant(inst_grant), .done(inst_done), .done_rdata(done_rdata),
        .req_ready(inst_req_ready), .rsp_valid(inst_rsp_valid),
        .rsp_rdata(inst_rsp_rdata), .pend(inst_pend),
        .pend_op(), .pend_addr(inst_addr), .pend_wdata()
    );

    mem_req_port data_port (
        .clk_in(clk_in), .rst_n(rst_n),
        .req_valid(data_req_valid), .req_op(data_req_op),
        .req_addr(data_req_addr), .req_wdata(data_req_wdata),
        .grant(data_grant), .done(data_done), .done_rdata(done_rdata),
        .req_ready(data_req_ready), .rsp_valid(data_rsp_valid),
        .rsp_rdata(data_rsp_rdata), .pend(data_pend),
        .pend_op(data_op), .pend_addr(data_addr), .pend_wdata(data_wdata)
    );

    // **************************************************
    // Shared memory path
    // **************************************************

    mem_bus_arbiter arbiter (
        .clk_in(clk_in), .rst_n(rst_n),
        .inst_pend(inst_pend), .inst_addr(inst_addr),
        .data_pend(data_pend), .data_op(data_op),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .mem_ready(mem_ready), .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_rdata(mem_rsp_rdata),
        .inst_grant(inst_grant), .data_grant(data_grant),
        .inst_done(inst_done), .data_done(data_done), .done_rdata(done_rdata),
        .mem_valid(mem_valid), .mem_op(mem_op),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    mem_delay_ram memory (
        .clk_in(clk_in), .rst_n(rst_n),
        .mem_valid(mem_valid), .mem_op(mem_op),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ready(mem_ready), .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_rdata(mem_rsp_rdata)
    );

    time_counter timebase (
        .clk_in(clk_in), .rst_n(rst_n),
        .mtimecmp(mtimecmp),
        .cycle_count(cycle_count), .time_us(time_us), .timer_irq(timer_irq)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_in,
    output logic rst_n
);

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in; // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk_in);
        rst_n <= 1'b1; // Released on the second edge
    end

endmodule

// File: mem_subsys_chk.sv
`timescale 1ns/1ps

module mem_subsys_chk (
    input logic                clk_in,
    input logic                rst_n,
    input logic                inst_req_valid,
    input logic                inst_req_ready,
    input logic                inst_rsp_valid,
    input logic                data_req_valid,
    input logic                data_req_ready,
    input logic                data_rsp_valid,
    input logic                mem_valid,
    input logic                mem_ready,
    input logic                mem_rsp_valid,
    input soc_pkg::arb_state_e arb_state
);
    import mem_pkg::*;
    import soc_pkg::*;

    // **************************************************
    // Source side
    // **************************************************

    rsp_exclusive: assert property (@(posedge clk_in) disable iff (!rst_n)
        !(inst_rsp_valid && data_rsp_valid))
        else $error("inst and data responses pulsed in the same cycle");

    inst_busy: assert property (@(posedge clk_in) disable iff (!rst_n)
        inst_req_valid && inst_req_ready |=> !inst_req_ready)
        else $error("inst_req_ready high in the cycle after an accept");

    data_busy: assert property (@(posedge clk_in) disable iff (!rst_n)
        data_req_valid && data_req_ready |=> !data_req_ready)
        else $error("data_req_ready high in the cycle after an accept");

    // **************************************************
    // Memory side
    // **************************************************

    // Response exactly mem_delay edges after the accept, not earlier
    mem_latency: assert property (@(posedge clk_in) disable iff (!rst_n)
        mem_valid && mem_ready |=> (!mem_rsp_valid) [*(mem_delay - 1)] ##1 mem_rsp_valid)
        else $error("memory response not mem_delay cycles after accept");

    rsp_owner: assert property (@(posedge clk_in) disable iff (!rst_n)
        mem_rsp_valid |-> arb_state != arb_idle)
        else $error("memory response while the arbiter has no owner");

endmodule

// File: tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;
    import mem_pkg::*;
    import soc_pkg::*;

    localparam int n_fill          = 16; // Whole 16-word window
    localparam int n_readback      = 40;
    localparam int n_mixed         = 40;
    localparam int n_contend       = 40;
    localparam int total_ops       = n_fill + n_readback + 2 * n_mixed + 2 * n_contend;
    localparam int watchdog_cycles = total_ops * (mem_delay + 6) * 2 + 100;

    typedef struct packed {
        logic                  is_read;
        logic [data_width-1:0] data;
    } rsp_exp_t;

    logic                  clk_in, rst_n;
    logic                  inst_req_valid, inst_req_ready, inst_rsp_valid;
    logic [addr_width-1:0] inst_req_addr;
    logic [data_width-1:0] inst_rsp_rdata;
    logic                  data_req_valid, data_req_ready, data_rsp_valid;
    mem_op_e               data_req_op;
    logic [addr_width-1:0] data_req_addr;
    logic [data_width-1:0] data_req_wdata, data_rsp_rdata;
    logic [time_width-1:0] mtimecmp, cycle_count, time_us;
    logic                  timer_irq;

    logic [31:0]           rng_state = 32'ha985_8b57;
    logic [data_width-1:0] model_mem [16];
    logic                  written [16];
    logic [time_width-1:0] model_cycles = '0; // Edges seen out of reset
    bit                    last_rsp_data = 1'b1; // Data counts as last granted after reset
    rsp_exp_t              inst_exp_q [$];
    rsp_exp_t              data_exp_q [$];
    int                    mismatch_count = 0;
    int                    fault_count = 0;

    tb_clock_gen clock_gen (.clk_in(clk_in), .rst_n(rst_n));

    mem_subsys mem_subsys_i (.*);

    bind mem_subsys mem_subsys_chk chk_i (
        .clk_in(clk_in), .rst_n(rst_n),
        .inst_req_valid(inst_req_valid), .inst_req_ready(inst_req_ready),
        .inst_rsp_valid(inst_rsp_valid),
        .data_req_valid(data_req_valid), .data_req_ready(data_req_ready),
        .data_rsp_valid(data_rsp_valid),
        .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_rsp_valid(mem_rsp_valid),
        .arb_state(arbiter.state)
    );

    always @(posedge clk_in) begin
        if (rst_n) model_cycles <= model_cycles + 1'b1;
    end

    // **************************************************
    // Helpers
    // **************************************************

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic read_expect(input logic [3:0] idx, input string name,
                               output rsp_exp_t exp);
        if (!written[idx]) begin
            $display("Read of word %0d in %s, which was never written", idx, name);
            fault_count++;
        end
        exp.is_read = 1'b1;
        exp.data    = model_mem[idx];
    endtask

    task automatic check_timebase(input string name);
        logic irq_exp;
        // Registered compare, so it lags time_us by one edge
        irq_exp = (model_cycles != 0) && ((model_cycles - 1) / fmax_mhz >= mtimecmp);
        check_value({name, " timer_irq"}, irq_exp, timer_irq);
        if (next_random() % 8 == 0) begin
            check_value({name, " cycle_count"}, model_cycles, cycle_count);
            check_value({name, " time_us"}, model_cycles / fmax_mhz, time_us);
        end
    endtask

    // Data mode is 0 fill, 1 reads, 2 writes or 3 random op
    task automatic run_phase(input string name, input int n_data, input int data_mode,
                             input int n_inst, input bit gaps);
        int          data_left, inst_left, data_gap, inst_gap, inst_streak, data_streak;
        bit          data_out, inst_out, data_out_wr, data_taken, inst_taken;
        bit          data_rsp_prev, inst_rsp_prev;
        bit          tie_open, tie_inst_first;
        logic [3:0]  data_out_addr, inst_out_addr, addr;
        logic [31:0] r;
        rsp_exp_t    exp;
        data_left      = n_data;
        inst_left      = n_inst;
        data_gap       = 0;
        inst_gap       = 0;
        inst_streak    = 0;
        data_streak    = 0;
        data_out       = 1'b0;
        inst_out       = 1'b0;
        data_out_wr    = 1'b0;
        data_rsp_prev  = 1'b0;
        inst_rsp_prev  = 1'b0;
        tie_open       = 1'b0;
        tie_inst_first = 1'b0;
        data_out_addr  = '0;
        inst_out_addr  = '0;
        while (data_left > 0 || inst_left > 0 || data_out || inst_out) begin
            @(posedge clk_in);
            check_timebase(name);
            if (data_rsp_prev) check_value({name, " data_req_ready"}, 1, data_req_ready);
            if (inst_rsp_prev) check_value({name, " inst_req_ready"}, 1, inst_req_ready);
            data_rsp_prev = data_rsp_valid;
            inst_rsp_prev = inst_rsp_valid;

            if (data_rsp_valid) begin
                if (data_exp_q.size() == 0) begin
                    $display("Data port gave a response with nothing outstanding in %s", name);
                    fault_count++;
                end else begin
                    exp = data_exp_q.pop_front();
                    if (exp.is_read) check_value({name, " data read"}, exp.data, data_rsp_rdata);
                end
                data_streak = inst_req_ready ? 0 : data_streak + 1; // Inst waiting
                inst_streak = 0;
                check_value({name, " data alternation"}, 1, data_streak <= 2);
                data_out = 1'b0;
                data_gap = gaps ? next_random() % 4 : 0;
            end
            if (inst_rsp_valid) begin
                if (inst_exp_q.size() == 0) begin
                    $display("Inst port gave a response with nothing outstanding in %s", name);
                    fault_count++;
                end else begin
                    exp = inst_exp_q.pop_front();
                    check_value({name, " inst read"}, exp.data, inst_rsp_rdata);
                end
                inst_streak = data_req_ready ? 0 : inst_streak + 1;
                data_streak = 0;
                check_value({name, " inst alternation"}, 1, inst_streak <= 2);
                inst_out = 1'b0;
                inst_gap = gaps ? next_random() % 4 : 0;
            end
            if (data_rsp_valid || inst_rsp_valid) begin
                if (tie_open) begin
                    check_value({name, " tie winner"}, tie_inst_first, inst_rsp_valid);
                end
                tie_open      = 1'b0;
                last_rsp_data = data_rsp_valid;
            end

            // Model follows the port accept
            data_taken = data_req_valid && data_req_ready;
            inst_taken = inst_req_valid && inst_req_ready;
            if (data_taken) begin
                if (data_req_op == op_write) begin
                    model_mem[data_req_addr[3:0]] = data_req_wdata;
                    written[data_req_addr[3:0]]   = 1'b1;
                    exp.is_read = 1'b0;
                    exp.data    = data_req_wdata;
                end else begin
                    read_expect(data_req_addr[3:0], name, exp);
                end
                data_exp_q.push_back(exp);
            end
            if (inst_taken) begin
                read_expect(inst_req_addr[3:0], name, exp);
                inst_exp_q.push_back(exp);
            end

            // Same-edge accepts make a tie that the loser of the last grant wins
            if (data_taken && inst_taken) begin
                tie_open       = 1'b1;
                tie_inst_first = last_rsp_data;
            end

            #1;
            if (data_taken) data_req_valid = 1'b0;
            if (inst_taken) inst_req_valid = 1'b0;

            if (!data_out && data_left > 0) begin
                if (data_gap > 0) begin
                    data_gap--;
                end else begin
                    r    = next_random();
                    addr = (data_mode == 0) ? 4'(n_data - data_left) : r[3:0];
                    case (data_mode)
                        0, 2:    data_req_op = op_write;
                        1:       data_req_op = op_read;
                        default: data_req_op = r[8] ? op_write : op_read;
                    endcase
                    // Keep writes off a word an inst read is waiting on
                    if (data_req_op == op_write && inst_out && addr == inst_out_addr) addr++;
                    data_req_addr  = addr_width'(addr);
                    data_req_wdata = next_random();
                    data_req_valid = 1'b1;
                    data_out       = 1'b1;
                    data_out_wr    = (data_req_op == op_write);
                    data_out_addr  = addr;
                    data_left--;
                end
            end
            if (!inst_out && inst_left > 0) begin
                if (inst_gap > 0) begin
                    inst_gap--;
                end else begin
                    r    = next_random();
                    addr = r[3:0];
                    if (data_out && data_out_wr && addr == data_out_addr) addr++;
                    inst_req_addr  = addr_width'(addr);
                    inst_req_valid = 1'b1;
                    inst_out       = 1'b1;
                    inst_out_addr  = addr;
                    inst_left--;
                end
            end
        end
    endtask

    // **************************************************
    // Main sequence and watchdog
    // **************************************************

    initial begin
        for (int i = 0; i < 16; i++) begin
            written[i] = 1'b0;
        end
        inst_req_valid = 1'b0;
        inst_req_addr  = '0;
        data_req_valid = 1'b0;
        data_req_op    = op_read;
        data_req_addr  = '0;
        data_req_wdata = '0;
        mtimecmp       = time_width'(10 + next_random() % 20); // Reached mid-run
        @(posedge rst_n);
        @(posedge clk_in);
        check_value("reset inst_req_ready", 1, inst_req_ready);
        check_value("reset data_req_ready", 1, data_req_ready);
        check_value("reset inst_rsp_valid", 0, inst_rsp_valid);
        check_value("reset data_rsp_valid", 0, data_rsp_valid);
        check_value("reset timer_irq", 0, timer_irq);

        run_phase("fill", n_fill, 0, 0, 1'b0);
        run_phase("readback", n_readback, 1, 0, 1'b1);
        run_phase("mixed", n_mixed, 2, n_mixed, 1'b1);
        run_phase("contention", n_contend, 3, n_contend, 1'b0);

        if (inst_exp_q.size() != 0 || data_exp_q.size() != 0) begin
            $display("Responses still owed at the end of the run");
            fault_count++;
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
        if (mismatch_count + fault_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_in);
        $display("Timeout: a response did not arrive within %0d cycles", watchdog_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: mem_subsys.f
mem_pkg.sv
soc_pkg.sv
mem_req_port.sv
mem_bus_arbiter.sv
mem_delay_ram.sv
time_counter.sv
mem_subsys.sv
tb_clock_gen.sv
mem_subsys_chk.sv
tb_mem_subsys.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - files:
      - mem_pkg.sv
      - soc_pkg.sv
      - mem_req_port.sv
      - mem_bus_arbiter.sv
      - mem_delay_ram.sv
      - time_counter.sv
      - mem_subsys.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - mem_subsys_chk.sv
      - tb_mem_subsys.sv
